//--- ifu_pkg.sv
`default_nettype none

package ifu_pkg;

    // instruction and address width, one word
    localparam int xlen = 32;
    // one compressed parcel
    localparam int half_w = 16;

    // addi x0, x0, 0
    // placed on the output while nothing is ready
    localparam logic [xlen-1:0] nop_insn = 32'h0000_0013;
    // all-zero word, the defined illegal instruction
    localparam logic [xlen-1:0] illegal_insn = 32'h0000_0000;

    // trap vector
    localparam int trap_len_default = 16;
    // cause bit positions
    localparam int trap_inst_misaligned = 0;
    localparam int trap_inst_access_fault = 1;
    localparam int trap_inst_page_fault = 12;

    // base isa major opcodes used by the expander
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;

    // fetch response from the instruction memory side
    typedef struct packed {
        // fetch address, may be halfword aligned
        logic [xlen-1:0] address;
        // whole aligned word containing the address
        logic [xlen-1:0] rdata;
        logic rdata_valid;
    } fetch_req_t;

    // one aligned instruction candidate
    typedef struct packed {
        // only low halfword is meaningful when compressed
        logic [xlen-1:0] insn;
        logic compressed;
        logic valid;
    } fetch_slot_t;

endpackage

`default_nettype wire

//--- ifu_halfword_align.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_halfword_align (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  ifu_pkg::fetch_req_t fetch_i,
    output ifu_pkg::fetch_slot_t slot_o
);

    // word index width, address without the byte offset
    localparam int word_w = ifu_pkg::xlen - 2;

    // addressed halfword of the current word
    logic [ifu_pkg::half_w-1:0] cur_half;
    logic cur_compressed;
    logic upper_half;

    // first half of a split full-width instruction
    logic [ifu_pkg::half_w-1:0] held_half;
    // word index of the held parcel
    logic [word_w-1:0] held_idx;
    logic held_valid;

    logic [word_w-1:0] next_idx;
    logic next_word;
    logic capture;

    // bit 1 picks the upper parcel
    assign upper_half = fetch_i.address[1];
    assign cur_half = upper_half ? fetch_i.rdata[ifu_pkg::xlen-1:ifu_pkg::half_w]
                                 : fetch_i.rdata[ifu_pkg::half_w-1:0];
    // low bits 2'b11 mark a 32-bit encoding
    assign cur_compressed = (cur_half[1:0] != 2'b11);

    // sequential word after the held one
    assign next_idx = held_idx + word_w'(1);
    assign next_word = fetch_i.rdata_valid && (fetch_i.address[ifu_pkg::xlen-1:2] == next_idx);

    // full-width instruction starting in the upper parcel
    assign capture = !flush_i && fetch_i.rdata_valid && !cur_compressed
                     && upper_half && !held_valid;

    // hold flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (flush_i) begin
            // redirect drops the partial instruction
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;
        end else if (held_valid && next_word) begin
            // second half consumed this cycle
            held_valid <= 1'b0;
        end
    end

    // held parcel and its word index
    always_ff @(posedge clk) begin
        if (capture) begin
            held_half <= cur_half;
            held_idx <= fetch_i.address[ifu_pkg::xlen-1:2];
        end
    end

    // slot selection
    always_comb begin
        slot_o = '0;
        if (held_valid) begin
            // join only with the next sequential word
            if (next_word) begin
                slot_o.insn = {fetch_i.rdata[ifu_pkg::half_w-1:0], held_half};
                slot_o.valid = 1'b1;
            end
        end else if (fetch_i.rdata_valid) begin
            if (cur_compressed) begin
                slot_o.insn = {{(ifu_pkg::xlen-ifu_pkg::half_w){1'b0}}, cur_half};
                slot_o.compressed = 1'b1;
                slot_o.valid = 1'b1;
            end else if (!upper_half) begin
                // aligned 32-bit instruction
                slot_o.insn = fetch_i.rdata;
                slot_o.valid = 1'b1;
            end
            // split case stays invalid, hold captures it
        end
    end

endmodule

`default_nettype wire

//--- ifu_rvc_expand.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_rvc_expand (
    input  logic [ifu_pkg::half_w-1:0] rvc_i,
    output logic [ifu_pkg::xlen-1:0]   insn_o
);

    // quadrant and funct3
    logic [1:0] quad;
    logic [2:0] funct3;

    // full register fields
    logic [4:0] rd_full;
    logic [4:0] rs2_full;
    // three-bit fields map to x8..x15
    logic [4:0] rd_p;
    logic [4:0] rs1_p;

    // reordered immediates
    logic [11:0] imm_4spn;
    logic [11:0] imm_lw;
    logic [11:0] imm_ci;
    logic [19:0] imm_lui;
    logic [20:0] imm_j;
    logic [12:0] imm_b;

    assign quad = rvc_i[1:0];
    assign funct3 = rvc_i[15:13];

    assign rd_full = rvc_i[11:7];
    assign rs2_full = rvc_i[6:2];
    // rd' for loads, rs2' for stores
    assign rd_p = {2'b01, rvc_i[4:2]};
    assign rs1_p = {2'b01, rvc_i[9:7]};

    // nzuimm[9:2], zero extended
    assign imm_4spn = {2'b00, rvc_i[10:7], rvc_i[12:11], rvc_i[5], rvc_i[6], 2'b00};
    // uimm[6:2], word scaled
    assign imm_lw = {5'b00000, rvc_i[5], rvc_i[12:10], rvc_i[6], 2'b00};
    // six-bit signed immediate
    assign imm_ci = {{6{rvc_i[12]}}, rvc_i[12], rvc_i[6:2]};
    // upper immediate, bits 17:12 sign extended
    assign imm_lui = {{14{rvc_i[12]}}, rvc_i[12], rvc_i[6:2]};
    // jump offset, bit 0 always clear
    assign imm_j = {{10{rvc_i[12]}}, rvc_i[8], rvc_i[10:9], rvc_i[6], rvc_i[7],
                    rvc_i[2], rvc_i[11], rvc_i[5:3], 1'b0};
    // branch offset
    assign imm_b = {{5{rvc_i[12]}}, rvc_i[6:5], rvc_i[2], rvc_i[11:10], rvc_i[4:3], 1'b0};

    always_comb begin
        insn_o = ifu_pkg::illegal_insn;
        case (quad)
            2'b00: begin
                case (funct3)
                    3'b000: begin
                        // c.addi4spn, zero immediate is reserved
                        if (imm_4spn != 12'd0) begin
                            insn_o = {imm_4spn, 5'd2, 3'b000, rd_p, ifu_pkg::op_op_imm};
                        end
                    end
                    3'b010: begin
                        // c.lw
                        insn_o = {imm_lw, rs1_p, 3'b010, rd_p, ifu_pkg::op_load};
                    end
                    3'b110: begin
                        // c.sw
                        insn_o = {imm_lw[11:5], rd_p, rs1_p, 3'b010, imm_lw[4:0],
                                  ifu_pkg::op_store};
                    end
                    default: insn_o = ifu_pkg::illegal_insn;
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'b000: begin
                        // c.addi, c.nop when rd is x0
                        insn_o = {imm_ci, rd_full, 3'b000, rd_full, ifu_pkg::op_op_imm};
                    end
                    3'b010: begin
                        // c.li
                        insn_o = {imm_ci, 5'd0, 3'b000, rd_full, ifu_pkg::op_op_imm};
                    end
                    3'b011: begin
                        // rd x2 is c.addi16sp, not in the subset
                        if (rd_full != 5'd2) begin
                            insn_o = {imm_lui, rd_full, ifu_pkg::op_lui};
                        end
                    end
                    3'b101: begin
                        // c.j, jal x0
                        insn_o = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], 5'd0,
                                  ifu_pkg::op_jal};
                    end
                    3'b110, 3'b111: begin
                        // c.beqz / c.bnez, funct3 low bit from inst[13]
                        insn_o = {imm_b[12], imm_b[10:5], 5'd0, rs1_p, 2'b00, rvc_i[13],
                                  imm_b[4:1], imm_b[11], ifu_pkg::op_branch};
                    end
                    default: insn_o = ifu_pkg::illegal_insn;
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: begin
                        // c.slli, shamt[5] set is reserved on rv32
                        if (!rvc_i[12]) begin
                            insn_o = {7'd0, rs2_full, rd_full, 3'b001, rd_full,
                                      ifu_pkg::op_op_imm};
                        end
                    end
                    3'b100: begin
                        if (rs2_full != 5'd0) begin
                            // c.mv adds to x0, c.add to rd
                            insn_o = {7'd0, rs2_full, rvc_i[12] ? rd_full : 5'd0, 3'b000,
                                      rd_full, ifu_pkg::op_op};
                        end else if (rd_full != 5'd0) begin
                            // c.jr links x0, c.jalr links x1
                            insn_o = {12'd0, rd_full, 3'b000, {4'd0, rvc_i[12]},
                                      ifu_pkg::op_jalr};
                        end
                    end
                    default: insn_o = ifu_pkg::illegal_insn;
                endcase
            end
            // quadrant 3 is not compressed
            default: insn_o = ifu_pkg::illegal_insn;
        endcase
    end

endmodule

`default_nettype wire

//--- ifu_fetch_out.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_out #(
    parameter int trap_len = ifu_pkg::trap_len_default
) (
    input  ifu_pkg::fetch_slot_t     slot_i,
    input  logic [ifu_pkg::xlen-1:0] expanded_i,
    input  logic                     ls_valid_i,
    input  logic                     trans_resp_valid_i,
    input  logic                     trans_page_fault_i,
    output logic [ifu_pkg::xlen-1:0] inst_data_o,
    output logic                     is_compressed_o,
    output logic                     stall_o,
    output logic [trap_len-1:0]      trap_bus_o
);

    // only live fetch-side trap source
    logic inst_page_fault;

    // nop while waiting, else expanded or raw word
    assign inst_data_o = !slot_i.valid    ? ifu_pkg::nop_insn :
                         slot_i.compressed ? expanded_i        : slot_i.insn;

    assign is_compressed_o = slot_i.valid && slot_i.compressed;

    // load/store unit owns memory, no fetch stall then
    assign stall_o = !slot_i.valid && !ls_valid_i;

    // only when the translation response is present
    assign inst_page_fault = trans_resp_valid_i && trans_page_fault_i;

    // page fault at its cause index, other causes stay zero
    always_comb begin
        trap_bus_o = '0;
        for (int i = 0; i < trap_len; i++) begin
            if (i == ifu_pkg::trap_inst_page_fault) begin
                trap_bus_o[i] = inst_page_fault;
            end
        end
    end

endmodule

`default_nettype wire

//--- ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
    parameter int trap_len = ifu_pkg::trap_len_default
) (
    input  logic                     clk,
    input  logic                     rst,
    input  ifu_pkg::fetch_req_t      fetch_i,
    input  logic                     flush_i,
    input  logic                     ls_valid_i,
    input  logic                     trans_resp_valid_i,
    input  logic                     trans_page_fault_i,
    output logic [ifu_pkg::xlen-1:0] inst_addr_o,
    output logic [ifu_pkg::xlen-1:0] inst_data_o,
    output logic                     is_compressed_o,
    output logic                     stall_o,
    output logic [trap_len-1:0]      trap_bus_o
);

    ifu_pkg::fetch_slot_t slot;
    logic [ifu_pkg::xlen-1:0] expanded;

    // pc travels with the instruction
    assign inst_addr_o = fetch_i.address;

    // halfword select and split join
    ifu_halfword_align align_i (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .fetch_i (fetch_i),
        .slot_o  (slot)
    );

    // only the low parcel is compressed
    ifu_rvc_expand expand_i (
        .rvc_i  (slot.insn[ifu_pkg::half_w-1:0]),
        .insn_o (expanded)
    );

    ifu_fetch_out #(
        .trap_len (trap_len)
    ) out_i (
        .slot_i             (slot),
        .expanded_i         (expanded),
        .ls_valid_i         (ls_valid_i),
        .trans_resp_valid_i (trans_resp_valid_i),
        .trans_page_fault_i (trans_page_fault_i),
        .inst_data_o        (inst_data_o),
        .is_compressed_o    (is_compressed_o),
        .stall_o            (stall_o),
        .trap_bus_o         (trap_bus_o)
    );

endmodule

`default_nettype wire

//--- ifu_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top_assert #(
    parameter int trap_len = ifu_pkg::trap_len_default
) (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     ls_valid_i,
    input wire logic                     stall_o,
    input wire logic [ifu_pkg::xlen-1:0] inst_data_o,
    input wire logic [trap_len-1:0]      trap_bus_o
);

    // only the page-fault cause may ever be set
    localparam logic [trap_len-1:0] live_mask = trap_len'(1) << ifu_pkg::trap_inst_page_fault;

    // load/store unit owning memory hides the fetch stall
    ls_hides_stall: assert property (@(posedge clk) disable iff (rst)
        ls_valid_i |-> !stall_o)
        else $error("stall_o high while ls_valid_i is high");

    // a stalled fetch always shows the nop
    stall_gives_nop: assert property (@(posedge clk) disable iff (rst)
        stall_o |-> (inst_data_o == ifu_pkg::nop_insn))
        else $error("inst_data_o is not the nop while stalled");

    // dead trap causes
    dead_traps_zero: assert property (@(posedge clk) disable iff (rst)
        (trap_bus_o & ~live_mask) == '0)
        else $error("trap bit other than the page fault is set");

endmodule

bind ifu_top ifu_top_assert #(.trap_len(trap_len)) top_assert_i (
    .clk         (clk),
    .rst         (rst),
    .ls_valid_i  (ls_valid_i),
    .stall_o     (stall_o),
    .inst_data_o (inst_data_o),
    .trap_bus_o  (trap_bus_o)
);

`default_nettype wire

//--- tb_ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_top;

    localparam int trap_len = ifu_pkg::trap_len_default;
    // eleven hex fields per trace line
    localparam int num_fields = 11;
    localparam int num_vec = 38;
    localparam int reset_cycles = 10;
    localparam int clk_period = 8;
    localparam int timeout_ns = (num_vec + reset_cycles + 20) * clk_period;

    logic clk;
    logic rst;
    ifu_pkg::fetch_req_t fetch;
    logic flush;
    logic ls_valid;
    logic resp_valid;
    logic page_fault;
    logic [ifu_pkg::xlen-1:0] inst_addr;
    logic [ifu_pkg::xlen-1:0] inst_data;
    logic is_compressed;
    logic stall;
    logic [trap_len-1:0] trap_bus;

    // flat trace storage, vector i starts at i * num_fields
    logic [31:0] trace_mem [0:num_vec*num_fields-1];

    ifu_top #(
        .trap_len (trap_len)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .fetch_i            (fetch),
        .flush_i            (flush),
        .ls_valid_i         (ls_valid),
        .trans_resp_valid_i (resp_valid),
        .trans_page_fault_i (page_fault),
        .inst_addr_o        (inst_addr),
        .inst_data_o        (inst_data),
        .is_compressed_o    (is_compressed),
        .stall_o            (stall),
        .trap_bus_o         (trap_bus)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first mismatch");
    endtask

    // one trace line onto the inputs
    task automatic apply_vector(input int idx);
        int base;
        base = idx * num_fields;
        flush = trace_mem[base][0];
        ls_valid = trace_mem[base+1][0];
        fetch.rdata_valid = trace_mem[base+2][0];
        resp_valid = trace_mem[base+3][0];
        page_fault = trace_mem[base+4][0];
        fetch.address = trace_mem[base+5];
        fetch.rdata = trace_mem[base+6];
    endtask

    task automatic check_vector(input int idx);
        int base;
        logic [31:0] exp_inst;
        logic exp_cmp;
        logic exp_stall;
        logic [trap_len-1:0] exp_trap;
        base = idx * num_fields;
        exp_inst = trace_mem[base+7];
        exp_cmp = trace_mem[base+8][0];
        exp_stall = trace_mem[base+9][0];
        // page fault sits alone at its cause index
        exp_trap = '0;
        exp_trap[ifu_pkg::trap_inst_page_fault] = trace_mem[base+10][0];
        assert (inst_data === exp_inst)
            else report_mismatch("inst_data_o", inst_data, exp_inst);
        assert (is_compressed === exp_cmp)
            else report_mismatch("is_compressed_o", 32'(is_compressed), 32'(exp_cmp));
        assert (stall === exp_stall)
            else report_mismatch("stall_o", 32'(stall), 32'(exp_stall));
        assert (trap_bus === exp_trap)
            else report_mismatch("trap_bus_o", 32'(trap_bus), 32'(exp_trap));
        // address is a plain pass-through
        assert (inst_addr === fetch.address)
            else report_mismatch("inst_addr_o", inst_addr, fetch.address);
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("watchdog expired, trace did not finish within %0d ns", timeout_ns);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation timeout");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fetch = '0;
        flush = 1'b0;
        ls_valid = 1'b0;
        resp_valid = 1'b0;
        page_fault = 1'b0;
        $readmemh("ifu_trace.txt", trace_mem);
        // last field missing means a short or absent file
        assert (!$isunknown(trace_mem[num_vec*num_fields-1]))
            else begin
                $display("trace file ifu_trace.txt could not be read completely");
                $display("*** TEST FAILED ***");
                $fatal(1, "bad trace file");
            end
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            #1;
            apply_vector(i);
            // sample just before the next rising edge
            #(clk_period - 2);
            check_vector(i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- ifu_top.f
ifu_pkg.sv
ifu_halfword_align.sv
ifu_rvc_expand.sv
ifu_fetch_out.sv
ifu_top.sv
ifu_top_assert.sv
tb_ifu_top.sv

//--- Bender.yml
package:
  name: ifu_top

sources:
  - ifu_pkg.sv
  - ifu_halfword_align.sv
  - ifu_rvc_expand.sv
  - ifu_fetch_out.sv
  - ifu_top.sv
  - target: test
    files:
      - ifu_top_assert.sv
      - tb_ifu_top.sv

//--- ifu_trace.txt
// flush ls_valid rdata_valid resp_valid page_fault address rdata
// then expected inst_data is_compressed stall page_fault_trap_bit
0 0 0 0 0 00000000 00000000 00000013 0 1 0
0 1 0 0 0 00000000 00000000 00000013 0 0 0
0 0 1 0 0 00000100 00500093 00500093 0 0 0
0 0 1 0 0 00000104 002081B3 002081B3 0 0 0
0 0 1 0 0 00000108 41440085 00108093 1 0 0
0 0 1 0 0 0000010A 41440085 00452483 1 0 0
0 0 1 0 0 0000010C E011A021 0080006F 1 0 0
0 0 1 0 0 0000010E E011A021 00041263 1 0 0
0 0 1 0 0 00000110 00004082 00000000 1 0 0
0 0 1 0 0 00000112 00000001 00000000 1 0 0
0 0 1 0 0 00000116 01130001 00000013 0 1 0
0 0 1 0 0 00000118 00850070 00700113 0 0 0
0 0 1 0 0 0000011A 00850070 00108093 1 0 0
0 0 1 0 0 0000011E 01130001 00000013 0 1 0
0 0 1 0 0 00000200 00850070 00000013 0 1 0
1 0 0 0 0 00000120 00850070 00000013 0 1 0
0 0 1 0 0 00000120 00850070 00C10613 1 0 0
0 0 1 1 1 00000124 00500093 00500093 0 0 1
0 0 1 0 1 00000128 002081B3 002081B3 0 0 0
0 0 1 1 0 00000128 002081B3 002081B3 0 0 0
0 0 0 1 1 00000128 00000000 00000013 0 1 1
0 1 1 0 0 0000012E 01130001 00000013 0 0 0
0 0 0 0 0 0000012E 00000000 00000013 0 1 0
0 0 1 0 0 00000130 00850070 00700113 0 0 0
0 0 1 0 0 00000130 00850070 00C10613 1 0 0
1 0 1 0 0 00000140 00500093 00500093 0 0 0
1 0 1 0 0 00000146 01130001 00000013 0 1 0
0 0 1 0 0 00000148 00850070 00C10613 1 0 0
0 0 1 0 0 0000014E 01130001 00000013 0 1 0
0 0 0 0 0 00000150 00000000 00000013 0 1 0
0 0 1 0 0 00000154 00850070 00000013 0 1 0
0 0 1 0 0 00000150 00850070 00700113 0 0 0
0 1 0 0 0 00000150 00000000 00000013 0 0 0
0 0 1 0 0 00000160 852E52FD FFF00293 1 0 0
0 0 1 0 0 00000162 852E52FD 00B00533 1 0 0
0 0 1 0 0 00000164 61859082 000080E7 1 0 0
0 0 1 0 0 00000166 61859082 000011B7 1 0 0
0 0 0 0 0 00000168 00000000 00000013 0 1 0
